// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --timing -Wno-fatal
TOP = decDivTb
FILELIST = sim.f

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== sim.f ====
+incdir+testbench
src/decDivPkg.sv
src/decDivDecode.sv
src/decDivCore.sv
src/decDivResult.sv
src/decDivUnit.sv
testbench/decDivTb.sv

// ==== src/decDivCore.sv ====
/*
 * Digit-serial restoring BCD divider. Produces DIGITS+1 quotient digits
 * by repeated ten's complement subtraction, then hands the top DIGITS on.
 */
`timescale 1ns/100ps

module decDivCore #(
	parameter int DIGITS = decDivPkg::NDIGITS
) (
	input logic clk,
	input logic rst,
	input logic jobValid,
	input decDivPkg::divJob_t job,
	output logic coreIdle,
	output logic outValid,
	output decDivPkg::divOut_t outJob,
	input logic resultReady
);

	// remainder and divisor carry one extra digit for the shift
	localparam int REM_W = (DIGITS + 1) * 4;
	localparam int CNT_W = $clog2(DIGITS + 1);

	typedef enum logic [1:0] {IDLE, DIVIDE, HOLD} coreState_t;

	// x - y in BCD, top bit is the carry out (set when x >= y)
	function automatic logic [REM_W:0] bcdSub(input logic [REM_W-1:0] x,
		input logic [REM_W-1:0] y);
		logic [REM_W-1:0] diff;
		logic carry;
		logic [4:0] s;
		carry = 1'b1;
		diff = '0;
		for (int i = 0; i <= DIGITS; i++) begin
			// add nine's complement digit, the initial carry makes it ten's
			s = {1'b0, x[i*4 +: 4]} + 5'd9 - {1'b0, y[i*4 +: 4]} + {4'd0, carry};
			if (s > 5'd9) begin
				diff[i*4 +: 4] = 4'(s - 5'd10);
				carry = 1'b1;
			end else begin
				diff[i*4 +: 4] = s[3:0];
				carry = 1'b0;
			end
		end
		return {carry, diff};
	endfunction

	coreState_t state;
	logic [REM_W-1:0] rem, divisor, quo;
	logic [3:0] qDigit;
	logic [CNT_W-1:0] digitCnt;
	logic [REM_W:0] subRes;
	logic [REM_W-1:0] quoNext;

	assign coreIdle = (state == IDLE);
	assign outValid = (state == HOLD);

	assign subRes = bcdSub(rem, divisor);
	// quotient with the finished digit appended
	assign quoNext = {quo[REM_W-5:0], qDigit};

	// ------------------------------
	// state machine and datapath
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (jobValid) begin
						outJob.sign <= job.sign;
						outJob.exp <= job.exp;
						outJob.kind <= job.kind;
						outJob.quo <= '0;
						outJob.leadZero <= 1'b0;
						rem <= {4'h0, job.sigA};
						divisor <= {4'h0, job.sigB};
						quo <= '0;
						qDigit <= 4'd0;
						digitCnt <= '0;
						// specials have nothing to divide
						state <= (job.kind == decDivPkg::spNone) ? DIVIDE : HOLD;
					end
				end
				DIVIDE: begin
					if (subRes[REM_W]) begin
						// remainder still covers the divisor
						rem <= subRes[REM_W-1:0];
						qDigit <= qDigit + 4'd1;
					end else begin
						// digit done, move on to the next position
						rem <= {rem[REM_W-5:0], 4'h0};
						quo <= quoNext;
						qDigit <= 4'd0;
						digitCnt <= digitCnt + 1'b1;
						if (digitCnt == CNT_W'(DIGITS)) begin
							// zero lead digit means the quotient is below one
							if (quoNext[REM_W-1 -: 4] == 4'h0) begin
								outJob.quo <= quoNext[REM_W-5:0];
								outJob.leadZero <= 1'b1;
							end else begin
								outJob.quo <= quoNext[REM_W-1:4];
								outJob.leadZero <= 1'b0;
							end
							state <= HOLD;
						end
					end
				end
				HOLD: begin
					if (resultReady)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== src/decDivDecode.sv ====
/*
 * Decode stage: queues incoming operand pairs, classifies the head entry
 * and normalizes its significands. Returns an input credit per pop.
 */
`timescale 1ns/100ps

module decDivDecode #(
	parameter int DIGITS = decDivPkg::NDIGITS,
	parameter int QUEUE_DEPTH = 2
) (
	input logic clk,
	input logic rst,
	input logic opValid,
	input decDivPkg::decFloat_t opA,
	input decDivPkg::decFloat_t opB,
	output logic opCredit,
	output logic jobValid,
	output decDivPkg::divJob_t job,
	input logic coreIdle
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	// count leading zero BCD digits, top digit first
	function automatic logic [7:0] leadZeros(input decDivPkg::bcdSig_t sig);
		logic [7:0] cnt;
		logic found;
		cnt = '0;
		found = 1'b0;
		for (int i = DIGITS - 1; i >= 0; i--) begin
			if (!found && sig[i*4 +: 4] == 4'd0)
				cnt = cnt + 8'd1;
			else
				found = 1'b1;
		end
		return cnt;
	endfunction

	decDivPkg::decFloat_t qA [QUEUE_DEPTH];
	decDivPkg::decFloat_t qB [QUEUE_DEPTH];
	logic [PTR_W-1:0] wrPtr, rdPtr;
	logic [CNT_W-1:0] count;
	logic pop;

	decDivPkg::decFloat_t headA, headB;
	logic aNan, bNan, aInf, bInf, aZero, bZero;
	logic [7:0] lzA, lzB;

	// ------------------------------
	// operand FIFO
	// ------------------------------
	assign jobValid = (count != '0);
	assign pop = jobValid && coreIdle;

	always_ff @(posedge clk) begin
		// sender only pushes while holding a credit, so there is always room
		if (opValid) begin
			qA[wrPtr] <= opA;
			qB[wrPtr] <= opB;
		end
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			opCredit <= 1'b0;
		end else begin
			if (opValid)
				wrPtr <= (wrPtr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + CNT_W'(opValid) - CNT_W'(pop);
			// credit goes back the cycle after the entry leaves
			opCredit <= pop;
		end
	end

	// ------------------------------
	// classify head entry
	// ------------------------------
	assign headA = qA[rdPtr];
	assign headB = qB[rdPtr];

	assign aNan = (&headA.exp) && (headA.sig != '0);
	assign bNan = (&headB.exp) && (headB.sig != '0);
	assign aInf = (&headA.exp) && (headA.sig == '0);
	assign bInf = (&headB.exp) && (headB.sig == '0);
	// zero significand at any finite exponent is a zero
	assign aZero = !(&headA.exp) && (headA.sig == '0);
	assign bZero = !(&headB.exp) && (headB.sig == '0);

	assign lzA = leadZeros(headA.sig);
	assign lzB = leadZeros(headB.sig);

	always_comb begin
		job.sign = headA.sign ^ headB.sign;
		// shift out leading zeros, exponent drops by a's count and rises by b's
		job.sigA = headA.sig << {lzA, 2'b00};
		job.sigB = headB.sig << {lzB, 2'b00};
		job.exp = decDivPkg::wideExp_t'(headA.exp) - decDivPkg::wideExp_t'(headB.exp)
			+ decDivPkg::wideExp_t'(lzB) - decDivPkg::wideExp_t'(lzA)
			+ decDivPkg::wideExp_t'(decDivPkg::EXP_BIAS);

		// priority order matters here
		if (aNan || bNan)
			job.kind = decDivPkg::spNan;
		else if ((aZero && bZero) || (aInf && bInf))
			job.kind = decDivPkg::spInvalid;
		else if (bZero)
			job.kind = decDivPkg::spDivZero;
		else if (aInf)
			job.kind = decDivPkg::spInf;
		else if (aZero || bInf)
			job.kind = decDivPkg::spZero;
		else
			job.kind = decDivPkg::spNone;
	end

endmodule

// ==== src/decDivPkg.sv ====
/*
 * Shared types for the decimal divide unit: operand format, flags,
 * special-case kinds and the job records passed between stages.
 */

package decDivPkg;

	// ------------------------------
	// format constants
	// ------------------------------
	// default significand length in BCD digits
	parameter int NDIGITS = 7;
	// biased binary exponent, all ones marks inf or NaN
	parameter int EXP_W = 8;
	parameter int EXP_BIAS = 127;

	typedef logic [NDIGITS*4-1:0] bcdSig_t;
	typedef logic [EXP_W-1:0] decExp_t;
	// working exponent, wide enough for difference plus bias plus shifts
	typedef logic signed [10:0] wideExp_t;

	// value is d1.d2...dN * 10^(exp - bias)
	typedef struct packed {
		logic sign;
		decExp_t exp;
		bcdSig_t sig;
	} decFloat_t;

	typedef struct packed {
		logic invalid;
		logic divByZero;
		logic overflow;
		logic underflow;
	} divFlags_t;

	// which fixed value the result stage emits, spNone means a real quotient
	typedef enum logic [2:0] {
		spNone,
		spNan,
		spInvalid,
		spDivZero,
		spInf,
		spZero
	} specialKind_t;

	// ------------------------------
	// stage records
	// ------------------------------
	// decode to core, significands already normalized
	typedef struct packed {
		bcdSig_t sigA;
		bcdSig_t sigB;
		logic sign;
		wideExp_t exp;
		specialKind_t kind;
	} divJob_t;

	// core to result
	typedef struct packed {
		bcdSig_t quo;
		logic leadZero;
		logic sign;
		wideExp_t exp;
		specialKind_t kind;
	} divOut_t;

endpackage

// ==== src/decDivResult.sv ====
/*
 * Result stage: picks special values, finishes the exponent with range
 * checks, registers the result and sends it under output credits.
 */
`timescale 1ns/100ps

module decDivResult #(
	parameter int DIGITS = decDivPkg::NDIGITS,
	parameter int OUT_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input logic outValid,
	input decDivPkg::divOut_t outJob,
	output logic resultReady,
	input logic resCredit,
	output logic resValid,
	output decDivPkg::decFloat_t result,
	output decDivPkg::divFlags_t resFlags
);

	localparam int CRED_W = $clog2(OUT_CREDITS + 1);
	// all-ones exponent, reserved for inf and NaN
	localparam int EXP_TOP = (1 << decDivPkg::EXP_W) - 1;

	logic full;
	logic [CRED_W-1:0] credits;
	logic load;
	decDivPkg::wideExp_t expAdj;
	decDivPkg::decFloat_t resNext;
	decDivPkg::divFlags_t flagsNext;

	// send whenever a result waits and a credit is held
	assign resValid = full && (credits != '0);
	assign resultReady = !full || resValid;
	assign load = outValid && resultReady;

	// ------------------------------
	// value selection
	// ------------------------------
	always_comb begin
		// quotient below one costs a decade
		expAdj = outJob.exp - decDivPkg::wideExp_t'(outJob.leadZero);
		flagsNext = '0;
		resNext.sign = outJob.sign;
		resNext.exp = '1;
		resNext.sig = '0;
		case (outJob.kind)
			decDivPkg::spNan, decDivPkg::spInvalid: begin
				// quiet NaN, 1 followed by zeros, positive
				resNext.sign = 1'b0;
				resNext.sig = {4'h1, {(DIGITS - 1) * 4{1'b0}}};
				flagsNext.invalid = (outJob.kind == decDivPkg::spInvalid);
			end
			decDivPkg::spDivZero, decDivPkg::spInf: begin
				flagsNext.divByZero = (outJob.kind == decDivPkg::spDivZero);
			end
			decDivPkg::spZero: begin
				resNext.exp = '0;
			end
			default: begin
				if (expAdj >= EXP_TOP) begin
					// too large, becomes signed infinity
					flagsNext.overflow = 1'b1;
				end else if (expAdj <= 0) begin
					// too small, flush to zero
					resNext.exp = '0;
					flagsNext.underflow = 1'b1;
				end else begin
					resNext.exp = expAdj[decDivPkg::EXP_W-1:0];
					resNext.sig = outJob.quo;
				end
			end
		endcase
	end

	// ------------------------------
	// result register and credits
	// ------------------------------
	always_ff @(posedge clk) begin
		if (load) begin
			result <= resNext;
			resFlags <= flagsNext;
		end
		if (rst) begin
			full <= 1'b0;
			credits <= CRED_W'(OUT_CREDITS);
		end else begin
			if (load)
				full <= 1'b1;
			else if (resValid)
				full <= 1'b0;
			// a credit returned while sending leaves the count as is
			credits <= credits - CRED_W'(resValid) + CRED_W'(resCredit);
		end
	end

endmodule

// ==== src/decDivUnit.sv ====
/*
 * Top level of the decimal divide unit. Wires decode, core and result
 * together and sets the shared parameters.
 */
`timescale 1ns/100ps

module decDivUnit #(
	parameter int DIGITS = decDivPkg::NDIGITS,
	parameter int QUEUE_DEPTH = 2,
	parameter int OUT_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input logic opValid,
	input decDivPkg::decFloat_t opA,
	input decDivPkg::decFloat_t opB,
	output logic opCredit,
	input logic resCredit,
	output logic resValid,
	output decDivPkg::decFloat_t result,
	output decDivPkg::divFlags_t resFlags
);

	// decode to core
	logic jobValid;
	logic coreIdle;
	decDivPkg::divJob_t job;

	// core to result
	logic outValid;
	logic resultReady;
	decDivPkg::divOut_t outJob;

	decDivDecode #(
		.DIGITS(DIGITS),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) decode (
		.clk(clk), .rst(rst),
		.opValid(opValid), .opA(opA), .opB(opB), .opCredit(opCredit),
		.jobValid(jobValid), .job(job), .coreIdle(coreIdle)
	);

	decDivCore #(
		.DIGITS(DIGITS)
	) core (
		.clk(clk), .rst(rst),
		.jobValid(jobValid), .job(job), .coreIdle(coreIdle),
		.outValid(outValid), .outJob(outJob), .resultReady(resultReady)
	);

	decDivResult #(
		.DIGITS(DIGITS),
		.OUT_CREDITS(OUT_CREDITS)
	) res (
		.clk(clk), .rst(rst),
		.outValid(outValid), .outJob(outJob), .resultReady(resultReady),
		.resCredit(resCredit), .resValid(resValid),
		.result(result), .resFlags(resFlags)
	);

endmodule

// ==== testbench/decDivTests.svh ====
/*
 * Directed tests for the divide unit, included into the testbench module.
 * Each task issues its operations; results are checked by the monitor.
 */

// ------------------------------
// normal quotients
// ------------------------------
task automatic testQuotients();
	longint one;
	sbEntry_t want;
	one = pow10(DIGITS - 1);
	want.flags = '0;
	// 6 / 2, exact
	want.res = makeNum(1'b0, 127, 3 * one);
	driveOp(makeNum(1'b0, 127, 6 * one), makeNum(1'b0, 127, 2 * one), want);
	// sign is the xor of the operand signs
	want.res = makeNum(1'b1, 127, 3 * one);
	driveOp(makeNum(1'b1, 127, 6 * one), makeNum(1'b0, 127, 2 * one), want);
	// 1 / 3 is below one, exponent drops a decade
	want.res = makeNum(1'b0, 126, (10 * one - 1) / 3);
	driveOp(makeNum(1'b0, 127, one), makeNum(1'b0, 127, 3 * one), want);
	// 2 / 3 truncated, last digit stays 6
	want.res = makeNum(1'b0, 126, 2 * (10 * one - 1) / 3);
	driveOp(makeNum(1'b0, 127, 2 * one), makeNum(1'b0, 127, 3 * one), want);
	issueOp(makeNum(1'b0, 130, 10 * one - 1), makeNum(1'b1, 125, one + 1));
endtask

// ------------------------------
// special operands
// ------------------------------
task automatic testSpecials();
	longint one;
	decDivPkg::decFloat_t nan, inf, zero, x;
	sbEntry_t want;
	one = pow10(DIGITS - 1);
	nan = makeNum(1'b0, EXP_TOP, one + 5);
	inf = makeNum(1'b0, EXP_TOP, 0);
	zero = makeNum(1'b0, 90, 0);
	x = makeNum(1'b1, 140, 4 * one + 2);
	// NaN in, quiet NaN out with no flag
	want.res = makeNum(1'b0, EXP_TOP, one);
	want.flags = '0;
	driveOp(x, nan, want);
	driveOp(nan, inf, want);
	want.flags = '{invalid: 1'b1, default: 1'b0};
	driveOp(zero, zero, want);
	driveOp(inf, inf, want);
	// x / 0 and inf / x, both signed infinity
	want.res = makeNum(1'b1, EXP_TOP, 0);
	want.flags = '{divByZero: 1'b1, default: 1'b0};
	driveOp(x, zero, want);
	want.flags = '0;
	driveOp(inf, x, want);
	// signed zeros
	want.res = makeNum(1'b1, 0, 0);
	driveOp(x, inf, want);
	driveOp(zero, x, want);
endtask

// ------------------------------
// leading zero digits, exponent range
// ------------------------------
task automatic testNormalize();
	longint one;
	sbEntry_t want;
	one = pow10(DIGITS - 1);
	issueOp(makeNum(1'b0, 130, 12345), makeNum(1'b0, 120, 3 * one + 7));
	issueOp(makeNum(1'b1, 100, 7 * one), makeNum(1'b0, 110, 300));
	issueOp(makeNum(1'b0, 127, 42), makeNum(1'b1, 127, 9));
	// 254 - 126 + bias lands on the reserved exponent
	want.res = makeNum(1'b1, EXP_TOP, 0);
	want.flags = '{overflow: 1'b1, default: 1'b0};
	driveOp(makeNum(1'b1, 254, 2 * one), makeNum(1'b0, 126, one), want);
	want.res = makeNum(1'b0, 0, 0);
	want.flags = '{underflow: 1'b1, default: 1'b0};
	driveOp(makeNum(1'b0, 5, one), makeNum(1'b0, 200, 2 * one), want);
	// quotient below one pulls the top exponent back in range
	issueOp(makeNum(1'b0, 254, one), makeNum(1'b0, 127, 2 * one));
endtask

task automatic testRandom();
	decDivPkg::decFloat_t a, b;
	for (int n = 0; n < 40; n++) begin
		a = randOperand();
		b = randOperand();
		issueOp(a, b);
	end
endtask

// ------------------------------
// credit flow control
// ------------------------------
task automatic testCredits();
	int burst, creditBase, resBase;
	longint one;
	one = pow10(DIGITS - 1);
	// queue, core and result register fill up behind the sent results
	burst = QUEUE_DEPTH + OUT_CREDITS + 2;
	@(posedge clk);
	autoReturn = 1'b0;
	@(negedge clk);
	creditBase = opCreditCount;
	resBase = resCount;
	for (int k = 1; k <= burst; k++)
		issueOp(makeNum(1'b0, 127, k * one), makeNum(1'b1, 126, 3 * one + k));
	repeat (STALL_CYCLES) @(negedge clk);
	if (resCount - resBase != OUT_CREDITS) begin
		$display("ERROR at %0d ns: resValid count expected %0d, got %0d",
			$time, OUT_CREDITS, resCount - resBase);
		stopRun("results kept leaving without output credits");
	end else if (opCreditCount - creditBase != burst - QUEUE_DEPTH) begin
		$display("ERROR at %0d ns: opCredit count expected %0d, got %0d",
			$time, burst - QUEUE_DEPTH, opCreditCount - creditBase);
		stopRun("input credits do not match the stalled pipeline");
	end else if (creditsHeld != 0) begin
		stopRun("sender still holds input credits with the result path stalled");
	end
	// hand the credits back, the rest drains in order
	@(posedge clk);
	autoReturn = 1'b1;
	@(negedge clk);
endtask

// ==== testbench/decDivTb.sv ====
/*
 * Testbench for the decimal divide unit. Sends operand pairs under input
 * credits and predicts every result with a reference model.
 * Results are checked in issue order; the directed tests are included below.
 */
`timescale 1ns/100ps

module decDivTb;

	localparam int DIGITS = decDivPkg::NDIGITS;
	localparam int QUEUE_DEPTH = 2;
	localparam int OUT_CREDITS = 2;
	localparam int EXP_TOP = (1 << decDivPkg::EXP_W) - 1;
	localparam int CYCLE_NS = 40;
	// quotients 5, specials 8, normalize and range 6, random 40, credits 6
	localparam int TOTAL_OPS = 65;
	localparam longint WATCHDOG_NS = longint'(TOTAL_OPS) * (DIGITS + 1) * 12 * CYCLE_NS
		+ 40000;
	// window in which a stalled result path must stay quiet
	localparam int STALL_CYCLES = (DIGITS + 1) * 12 * 2;

	typedef struct packed {
		decDivPkg::decFloat_t res;
		decDivPkg::divFlags_t flags;
	} sbEntry_t;

	logic clk = 1'b0;
	logic rst, opValid, opCredit, resCredit, resValid;
	decDivPkg::decFloat_t opA, opB, result;
	decDivPkg::divFlags_t resFlags;

	// expected results in issue order
	sbEntry_t scoreboard[$];
	sbEntry_t head;
	logic [15:0] lfsr;
	logic autoReturn;
	int creditsHeld, opsSent, opCreditCount, resCount, returnPending;

	decDivUnit #(
		.DIGITS(DIGITS),
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) uut (
		.clk(clk), .rst(rst),
		.opValid(opValid), .opA(opA), .opB(opB), .opCredit(opCredit),
		.resCredit(resCredit), .resValid(resValid),
		.result(result), .resFlags(resFlags)
	);

	initial begin
		forever #(CYCLE_NS / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		stopRun("watchdog expired before all results arrived");
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic stopRun(input string why);
		$display("ERRORS FOUND");
		$fatal(1, "%s", why);
	endtask

	function automatic longint pow10(input int n);
		longint v;
		v = 1;
		for (int i = 0; i < n; i++)
			v = v * 10;
		return v;
	endfunction

	function automatic longint bcdToInt(input decDivPkg::bcdSig_t s);
		longint v;
		v = 0;
		for (int i = DIGITS - 1; i >= 0; i--)
			v = v * 10 + longint'(s[i*4 +: 4]);
		return v;
	endfunction

	function automatic decDivPkg::bcdSig_t intToBcd(input longint v);
		decDivPkg::bcdSig_t s;
		longint rest;
		rest = v;
		s = '0;
		for (int i = 0; i < DIGITS; i++) begin
			s[i*4 +: 4] = 4'(rest % 10);
			rest = rest / 10;
		end
		return s;
	endfunction

	// digits given as the integer d1d2...dN
	function automatic decDivPkg::decFloat_t makeNum(input logic s, input int e,
		input longint digits);
		decDivPkg::decFloat_t v;
		v.sign = s;
		v.exp = decDivPkg::decExp_t'(e);
		v.sig = intToBcd(digits);
		return v;
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic nextLfsrBit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic int unsigned randBits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(nextLfsrBit());
		return v;
	endfunction

	function automatic decDivPkg::decFloat_t randOperand();
		decDivPkg::decFloat_t v;
		v.sign = nextLfsrBit();
		// exponents mostly well inside the range
		v.exp = decDivPkg::decExp_t'(64 + randBits(7));
		for (int i = 0; i < DIGITS; i++)
			v.sig[i*4 +: 4] = 4'(randBits(4) % 10);
		return v;
	endfunction

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic sbEntry_t modelDivide(input decDivPkg::decFloat_t a,
		input decDivPkg::decFloat_t b);
		sbEntry_t w;
		longint one, va, vb, q;
		int e, lzA, lzB;
		logic aTop, bTop, aNan, bNan, aInf, bInf, aZero, bZero;
		one = pow10(DIGITS - 1);
		va = bcdToInt(a.sig);
		vb = bcdToInt(b.sig);
		aTop = (int'(a.exp) == EXP_TOP);
		bTop = (int'(b.exp) == EXP_TOP);
		aNan = aTop && (va != 0);
		bNan = bTop && (vb != 0);
		aInf = aTop && (va == 0);
		bInf = bTop && (vb == 0);
		aZero = !aTop && (va == 0);
		bZero = !bTop && (vb == 0);
		w.res.sign = a.sign ^ b.sign;
		w.res.exp = '1;
		w.res.sig = '0;
		w.flags = '0;
		if (aNan || bNan || (aZero && bZero) || (aInf && bInf)) begin
			// quiet NaN 1.000... with invalid set only when no operand is a NaN
			w.res.sign = 1'b0;
			w.res.sig = intToBcd(one);
			w.flags.invalid = !(aNan || bNan);
		end else if (bZero || aInf) begin
			w.flags.divByZero = bZero;
		end else if (aZero || bInf) begin
			w.res.exp = '0;
		end else begin
			lzA = 0;
			lzB = 0;
			while (va < one) begin
				va = va * 10;
				lzA++;
			end
			while (vb < one) begin
				vb = vb * 10;
				lzB++;
			end
			e = int'(a.exp) - int'(b.exp) - lzA + lzB + decDivPkg::EXP_BIAS;
			q = va * pow10(DIGITS) / vb;
			// DIGITS+1 digits means the quotient is at least one
			if (q >= pow10(DIGITS))
				q = q / 10;
			else
				e = e - 1;
			if (e >= EXP_TOP) begin
				w.flags.overflow = 1'b1;
			end else if (e <= 0) begin
				w.res.exp = '0;
				w.flags.underflow = 1'b1;
			end else begin
				w.res.exp = decDivPkg::decExp_t'(e);
				w.res.sig = intToBcd(q);
			end
		end
		return w;
	endfunction

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic checkResult(input string name, input decDivPkg::decFloat_t want,
		input decDivPkg::decFloat_t got);
		if (got !== want) begin
			$write("ERROR at %0d ns: %s expected sign=%b exp=%0d sig=%h",
				$time, name, want.sign, want.exp, want.sig);
			$display(", got sign=%b exp=%0d sig=%h", got.sign, got.exp, got.sig);
			stopRun("result value differs from the reference model");
		end
	endtask

	task automatic checkFlags(input string name, input decDivPkg::divFlags_t want,
		input decDivPkg::divFlags_t got);
		if (got !== want) begin
			$display("ERROR at %0d ns: %s expected %b, got %b", $time, name, want, got);
			stopRun("result flags differ from the reference model");
		end
	endtask

	// ------------------------------
	// sender, consumer and monitor
	// ------------------------------
	task automatic driveOp(input decDivPkg::decFloat_t a, input decDivPkg::decFloat_t b,
		input sbEntry_t want);
		// only send while holding an input credit
		while (creditsHeld == 0)
			@(negedge clk);
		opValid = 1'b1;
		opA = a;
		opB = b;
		creditsHeld--;
		opsSent++;
		scoreboard.push_back(want);
		@(negedge clk);
		opValid = 1'b0;
	endtask

	task automatic issueOp(input decDivPkg::decFloat_t a, input decDivPkg::decFloat_t b);
		driveOp(a, b, modelDivide(a, b));
	endtask

	task automatic waitDrain();
		while (scoreboard.size() != 0 || returnPending != 0)
			@(negedge clk);
	endtask

	// consumer frees one slot per cycle while returning is on
	always @(negedge clk) begin
		resCredit = autoReturn && (returnPending > 0);
	end

	always @(posedge clk) begin
		if (!rst) begin
			if (opCredit) begin
				creditsHeld++;
				opCreditCount++;
			end
			if (resCredit)
				returnPending--;
			if (resValid) begin
				resCount++;
				returnPending++;
				if (scoreboard.size() == 0) begin
					stopRun("resValid pulsed with no operation outstanding");
				end else begin
					head = scoreboard.pop_front();
					checkResult("result", head.res, result);
					checkFlags("resFlags", head.flags, resFlags);
				end
			end
			if (opCreditCount > opsSent)
				stopRun("unit returned more input credits than operations sent");
		end
	end

	`include "decDivTests.svh"

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		rst = 1'b1;
		opValid = 1'b0;
		opA = '0;
		opB = '0;
		resCredit = 1'b0;
		lfsr = 16'd96;
		autoReturn = 1'b1;
		creditsHeld = QUEUE_DEPTH;
		opsSent = 0;
		opCreditCount = 0;
		resCount = 0;
		returnPending = 0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		testQuotients();
		waitDrain();
		testSpecials();
		waitDrain();
		testNormalize();
		waitDrain();
		testRandom();
		waitDrain();
		testCredits();
		waitDrain();
		if (opCreditCount != opsSent) begin
			$display("ERROR at %0d ns: opCredit count expected %0d, got %0d",
				$time, opsSent, opCreditCount);
			stopRun("input credits returned do not match operations sent");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule
